//--- source/legv8_isa_pkg.sv
package legv8_isa_pkg;

  // data and address width
  localparam int XLEN = 32;

  // x31 reads as zero and ignores writes
  localparam logic [4:0] REG_ZR = 5'd31;

  // r-format opcodes
  localparam logic [10:0] OP_ADD  = 11'b10001011000;
  localparam logic [10:0] OP_SUB  = 11'b11001011000;
  localparam logic [10:0] OP_AND  = 11'b10001010000;
  localparam logic [10:0] OP_ORR  = 11'b10101010000;

  // d-format opcodes
  localparam logic [10:0] OP_LDUR = 11'b11111000010;
  localparam logic [10:0] OP_STUR = 11'b11111000000;

  // cb-format opcode, only the top 8 bits
  localparam logic [7:0]  OP_CBZ  = 8'b10110100;

  typedef struct packed {
    logic [10:0] opcode;
    logic [4:0]  rm;
    logic [5:0]  shamt;
    logic [4:0]  rn;
    logic [4:0]  rd;
  } r_fmt_t;

  typedef struct packed {
    logic [10:0] opcode;
    // signed byte offset
    logic [8:0]  dt_address;
    logic [1:0]  op2;
    logic [4:0]  rn;
    logic [4:0]  rt;
  } d_fmt_t;

  typedef struct packed {
    logic [7:0]  opcode;
    // signed word offset
    logic [18:0] cond_br_address;
    logic [4:0]  rt;
  } cb_fmt_t;

  // one instruction word, three views
  typedef union packed {
    r_fmt_t  r;
    d_fmt_t  d;
    cb_fmt_t cb;
  } inst_u;

endpackage

//--- source/legv8_pipe_pkg.sv
package legv8_pipe_pkg;

  // register index and carried opcode widths
  localparam int REG_IDX_W = 5;
  localparam int OPC_W     = 11;

  // alu operation class, set by the decoder
  typedef enum logic [1:0] {
    // address computation
    ALU_ADD    = 2'b00,
    // cbz zero test on operand b
    ALU_PASS_B = 2'b01,
    // resolved late from the opcode
    ALU_RTYPE  = 2'b10
  } alu_op_t;

  // control bundle for ex, mem and wb
  typedef struct packed {
    logic    reg_write;
    logic    mem_to_reg;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    // b operand is the immediate
    logic    alu_src;
    alu_op_t alu_op;
  } ctrl_t;

endpackage

//--- source/id_ex_if.sv
interface id_ex_if;
  import legv8_isa_pkg::*;
  import legv8_pipe_pkg::*;

  // one-cycle strobe, fields below only meaningful with it
  logic                 valid;
  ctrl_t                ctrl;
  logic [XLEN-1:0]      pc;
  logic [XLEN-1:0]      rd_data1;
  logic [XLEN-1:0]      rd_data2;
  logic [XLEN-1:0]      sgn_ext_imm;
  // kept for late r-type alu select
  logic [OPC_W-1:0]     opcode;
  logic [REG_IDX_W-1:0] rd;

  // pipeline register side
  modport stage_out (output valid, ctrl, pc, rd_data1, rd_data2, sgn_ext_imm, opcode, rd);

  // execute side
  modport stage_in (input valid, ctrl, pc, rd_data1, rd_data2, sgn_ext_imm, opcode, rd);

endinterface

//--- source/inst_decoder.sv
module inst_decoder (
  input  legv8_isa_pkg::inst_u                  instr,
  output legv8_pipe_pkg::ctrl_t                 ctrl,
  output logic [legv8_pipe_pkg::REG_IDX_W-1:0]  rn_idx,
  output logic [legv8_pipe_pkg::REG_IDX_W-1:0]  rm_idx,
  output logic [legv8_pipe_pkg::REG_IDX_W-1:0]  rd,
  output logic [legv8_isa_pkg::XLEN-1:0]        sgn_ext_imm,
  output logic [legv8_pipe_pkg::OPC_W-1:0]      opcode,
  output logic                                  illegal
);
  import legv8_isa_pkg::*;
  import legv8_pipe_pkg::*;

  always_comb
  begin
    // defaults are a bubble with r-format field positions
    ctrl        = '0;
    rn_idx      = instr.r.rn;
    rm_idx      = instr.r.rm;
    // rd and rt share bits 4:0 in every format
    rd          = instr.r.rd;
    sgn_ext_imm = '0;
    opcode      = instr.r.opcode;
    illegal     = 1'b0;

    // cb opcode is only 8 bits wide, so test it first
    if (instr.cb.opcode == OP_CBZ)
    begin
      ctrl.branch = 1'b1;
      ctrl.alu_op = ALU_PASS_B;
      // rt goes through read port 2 for the zero test
      rm_idx      = instr.cb.rt;
      // word offset to byte offset
      sgn_ext_imm = {{(XLEN-21){instr.cb.cond_br_address[18]}},
                     instr.cb.cond_br_address, 2'b00};
    end
    else
    begin
      case (instr.r.opcode)
        OP_ADD, OP_SUB, OP_AND, OP_ORR:
        begin
          ctrl.reg_write = 1'b1;
          ctrl.alu_op    = ALU_RTYPE;
        end
        OP_LDUR:
        begin
          ctrl.reg_write  = 1'b1;
          ctrl.mem_to_reg = 1'b1;
          ctrl.mem_read   = 1'b1;
          ctrl.alu_src    = 1'b1;
          ctrl.alu_op     = ALU_ADD;
          sgn_ext_imm     = {{(XLEN-9){instr.d.dt_address[8]}}, instr.d.dt_address};
        end
        OP_STUR:
        begin
          ctrl.mem_write = 1'b1;
          ctrl.alu_src   = 1'b1;
          ctrl.alu_op    = ALU_ADD;
          // store data comes from rt on port 2
          rm_idx         = instr.d.rt;
          sgn_ext_imm    = {{(XLEN-9){instr.d.dt_address[8]}}, instr.d.dt_address};
        end
        default:
        begin
          // unknown opcode, control stays all zero
          illegal = 1'b1;
        end
      endcase
    end
  end

endmodule

//--- source/reg_file.sv
module reg_file (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [legv8_pipe_pkg::REG_IDX_W-1:0] rd_idx1,
  input  logic [legv8_pipe_pkg::REG_IDX_W-1:0] rd_idx2,
  output logic [legv8_isa_pkg::XLEN-1:0]       rd_data1,
  output logic [legv8_isa_pkg::XLEN-1:0]       rd_data2,
  input  logic                                 wb_en,
  input  logic [legv8_pipe_pkg::REG_IDX_W-1:0] wb_rd,
  input  logic [legv8_isa_pkg::XLEN-1:0]       wb_data
);
  import legv8_isa_pkg::*;
  import legv8_pipe_pkg::*;

  // x0..x30 only, x31 has no storage
  logic [XLEN-1:0] regs [0:30];

  // zero register, then same-cycle write bypass, then storage
  function automatic logic [XLEN-1:0] read_port(input logic [REG_IDX_W-1:0] idx);
    if (idx == REG_ZR)
      return '0;
    else if (wb_en && (wb_rd == idx))
      return wb_data;
    else
      return regs[idx];
  endfunction

  always_comb
  begin
    rd_data1 = read_port(rd_idx1);
    rd_data2 = read_port(rd_idx2);
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 31; i++)
        regs[i] <= '0;
    end
    // writes to x31 dropped
    else if (wb_en && (wb_rd != REG_ZR))
      regs[wb_rd] <= wb_data;
  end

endmodule

//--- source/id_ex_reg.sv
module id_ex_reg (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 issue,
  input  legv8_pipe_pkg::ctrl_t                ctrl,
  input  logic                                 illegal,
  input  logic [legv8_isa_pkg::XLEN-1:0]       pc,
  input  logic [legv8_isa_pkg::XLEN-1:0]       rd_data1,
  input  logic [legv8_isa_pkg::XLEN-1:0]       rd_data2,
  input  logic [legv8_isa_pkg::XLEN-1:0]       sgn_ext_imm,
  input  logic [legv8_pipe_pkg::OPC_W-1:0]     opcode,
  input  logic [legv8_pipe_pkg::REG_IDX_W-1:0] rd,
  id_ex_if.stage_out                           out,
  output logic                                 illegal_q
);

  // strobe and controls, bubble on reset and on idle cycles
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out.valid <= 1'b0;
      out.ctrl  <= '0;
      illegal_q <= 1'b0;
    end
    else
    begin
      out.valid <= issue;
      out.ctrl  <= issue ? ctrl : '0;
      illegal_q <= issue & illegal;
    end
  end

  // payload only moves on issue, holds otherwise
  always_ff @(posedge clk)
  begin
    if (issue)
    begin
      out.pc          <= pc;
      out.rd_data1    <= rd_data1;
      out.rd_data2    <= rd_data2;
      out.sgn_ext_imm <= sgn_ext_imm;
      // opcode rides along for the r-type alu select
      out.opcode      <= opcode;
      out.rd          <= rd;
    end
  end

endmodule

//--- source/ex_stage.sv
module ex_stage (
  input  logic                                 clk,
  input  logic                                 rst_n,
  id_ex_if.stage_in                            in,
  input  logic                                 illegal_q,
  output logic                                 ex_valid,
  output logic                                 ex_ctrl_reg_write,
  output logic                                 ex_mem_to_reg,
  output logic                                 ex_mem_read,
  output logic                                 ex_mem_write,
  output logic [legv8_pipe_pkg::REG_IDX_W-1:0] ex_rd,
  output logic [legv8_isa_pkg::XLEN-1:0]       ex_alu_result,
  output logic [legv8_isa_pkg::XLEN-1:0]       ex_store_data,
  output logic [legv8_isa_pkg::XLEN-1:0]       ex_branch_target,
  output logic                                 ex_branch_taken,
  output logic                                 ex_illegal
);
  import legv8_isa_pkg::*;
  import legv8_pipe_pkg::*;

  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic            taken;

  // immediate for loads and stores, register otherwise
  assign op_b = in.ctrl.alu_src ? in.sgn_ext_imm : in.rd_data2;

  always_comb
  begin
    case (in.ctrl.alu_op)
      ALU_ADD:    alu_res = in.rd_data1 + op_b;
      ALU_PASS_B: alu_res = op_b;
      ALU_RTYPE:
      begin
        // late resolve from the carried opcode
        case (in.opcode)
          OP_SUB:  alu_res = in.rd_data1 - op_b;
          OP_AND:  alu_res = in.rd_data1 & op_b;
          OP_ORR:  alu_res = in.rd_data1 | op_b;
          default: alu_res = in.rd_data1 + op_b;
        endcase
      end
      default:    alu_res = '0;
    endcase
  end

  // cbz, taken when rt reads zero
  assign taken = in.ctrl.branch && (alu_res == '0);

  // controls gated by valid so a bubble never writes or branches
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ex_valid          <= 1'b0;
      ex_ctrl_reg_write <= 1'b0;
      ex_mem_to_reg     <= 1'b0;
      ex_mem_read       <= 1'b0;
      ex_mem_write      <= 1'b0;
      ex_branch_taken   <= 1'b0;
      ex_illegal        <= 1'b0;
    end
    else
    begin
      ex_valid          <= in.valid;
      ex_ctrl_reg_write <= in.valid & in.ctrl.reg_write;
      ex_mem_to_reg     <= in.valid & in.ctrl.mem_to_reg;
      ex_mem_read       <= in.valid & in.ctrl.mem_read;
      ex_mem_write      <= in.valid & in.ctrl.mem_write;
      ex_branch_taken   <= in.valid & taken;
      ex_illegal        <= in.valid & illegal_q;
    end
  end

  // results hold between valid cycles
  always_ff @(posedge clk)
  begin
    if (in.valid)
    begin
      ex_rd            <= in.rd;
      ex_alu_result    <= alu_res;
      // store data is rt, read on port 2
      ex_store_data    <= in.rd_data2;
      ex_branch_target <= in.pc + in.sgn_ext_imm;
    end
  end

endmodule

//--- source/id_ex_core.sv
module id_ex_core (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 instr_valid,
  input  logic [legv8_isa_pkg::XLEN-1:0]       instr,
  input  logic [legv8_isa_pkg::XLEN-1:0]       instr_pc,
  input  logic                                 wb_en,
  input  logic [legv8_pipe_pkg::REG_IDX_W-1:0] wb_rd,
  input  logic [legv8_isa_pkg::XLEN-1:0]       wb_data,
  output logic                                 ex_valid,
  output logic                                 ex_ctrl_reg_write,
  output logic                                 ex_mem_to_reg,
  output logic                                 ex_mem_read,
  output logic                                 ex_mem_write,
  output logic [legv8_pipe_pkg::REG_IDX_W-1:0] ex_rd,
  output logic [legv8_isa_pkg::XLEN-1:0]       ex_alu_result,
  output logic [legv8_isa_pkg::XLEN-1:0]       ex_store_data,
  output logic                                 ex_branch_taken,
  output logic [legv8_isa_pkg::XLEN-1:0]       ex_branch_target,
  output logic                                 ex_illegal
);
  import legv8_isa_pkg::*;
  import legv8_pipe_pkg::*;

  // decode stage outputs
  ctrl_t                dec_ctrl;
  logic [REG_IDX_W-1:0] dec_rn;
  logic [REG_IDX_W-1:0] dec_rm;
  logic [REG_IDX_W-1:0] dec_rd;
  logic [XLEN-1:0]      dec_imm;
  logic [OPC_W-1:0]     dec_opcode;
  logic                 dec_illegal;
  // register file read data
  logic [XLEN-1:0]      rf_data1;
  logic [XLEN-1:0]      rf_data2;
  logic                 illegal_q;

  // id/ex bundle
  id_ex_if id_ex_bus ();

  inst_decoder u_dec (
    .instr       (instr),
    .ctrl        (dec_ctrl),
    .rn_idx      (dec_rn),
    .rm_idx      (dec_rm),
    .rd          (dec_rd),
    .sgn_ext_imm (dec_imm),
    .opcode      (dec_opcode),
    .illegal     (dec_illegal)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_idx1  (dec_rn),
    .rd_idx2  (dec_rm),
    .rd_data1 (rf_data1),
    .rd_data2 (rf_data2),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  id_ex_reg u_id_ex (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue       (instr_valid),
    .ctrl        (dec_ctrl),
    .illegal     (dec_illegal),
    .pc          (instr_pc),
    .rd_data1    (rf_data1),
    .rd_data2    (rf_data2),
    .sgn_ext_imm (dec_imm),
    .opcode      (dec_opcode),
    .rd          (dec_rd),
    .out         (id_ex_bus.stage_out),
    .illegal_q   (illegal_q)
  );

  ex_stage u_ex (
    .clk               (clk),
    .rst_n             (rst_n),
    .in                (id_ex_bus.stage_in),
    .illegal_q         (illegal_q),
    .ex_valid          (ex_valid),
    .ex_ctrl_reg_write (ex_ctrl_reg_write),
    .ex_mem_to_reg     (ex_mem_to_reg),
    .ex_mem_read       (ex_mem_read),
    .ex_mem_write      (ex_mem_write),
    .ex_rd             (ex_rd),
    .ex_alu_result     (ex_alu_result),
    .ex_store_data     (ex_store_data),
    .ex_branch_target  (ex_branch_target),
    .ex_branch_taken   (ex_branch_taken),
    .ex_illegal        (ex_illegal)
  );

endmodule

//--- verification/id_ex_core_tb.sv
module id_ex_core_tb;
  import legv8_isa_pkg::*;

  // watchdog budget
  localparam int CLK_PERIOD      = 4;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 400;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] instr_pc;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        ex_valid;
  logic        ex_ctrl_reg_write;
  logic        ex_mem_to_reg;
  logic        ex_mem_read;
  logic        ex_mem_write;
  logic [4:0]  ex_rd;
  logic [31:0] ex_alu_result;
  logic [31:0] ex_store_data;
  logic        ex_branch_taken;
  logic [31:0] ex_branch_target;
  logic        ex_illegal;

  // reference register contents, x31 stays zero
  logic [31:0] model_regs [0:31];
  logic [31:0] lcg_state;

  id_ex_core uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .instr_valid       (instr_valid),
    .instr             (instr),
    .instr_pc          (instr_pc),
    .wb_en             (wb_en),
    .wb_rd             (wb_rd),
    .wb_data           (wb_data),
    .ex_valid          (ex_valid),
    .ex_ctrl_reg_write (ex_ctrl_reg_write),
    .ex_mem_to_reg     (ex_mem_to_reg),
    .ex_mem_read       (ex_mem_read),
    .ex_mem_write      (ex_mem_write),
    .ex_rd             (ex_rd),
    .ex_alu_result     (ex_alu_result),
    .ex_store_data     (ex_store_data),
    .ex_branch_taken   (ex_branch_taken),
    .ex_branch_target  (ex_branch_target),
    .ex_illegal        (ex_illegal)
  );

  // half period of 2
  always #2 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // instruction encoders
  function automatic logic [31:0] r_word(input logic [10:0] opc, input logic [4:0] rm,
                                         input logic [4:0] rn, input logic [4:0] rd);
    return {opc, rm, 6'd0, rn, rd};
  endfunction

  function automatic logic [31:0] d_word(input logic [10:0] opc, input logic [8:0] off,
                                         input logic [4:0] rn, input logic [4:0] rt);
    return {opc, off, 2'b00, rn, rt};
  endfunction

  function automatic logic [31:0] cb_word(input logic [18:0] off, input logic [4:0] rt);
    return {OP_CBZ, off, rt};
  endfunction

  function automatic logic [31:0] sext9(input logic [8:0] off);
    return {{23{off[8]}}, off};
  endfunction

  // expected r-format result
  function automatic logic [31:0] rtype_ref(input logic [10:0] opc, input logic [31:0] a,
                                            input logic [31:0] b);
    case (opc)
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_ORR:  return a | b;
      default: return a + b;
    endcase
  endfunction

  task automatic word_check(input string test, input string field, input logic [31:0] exp,
                            input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("[ERROR] %s: %s expected %08h, actual %08h", test, field, exp, act);
      $display(">>> FAIL");
      $fatal(1, "%s: wrong value on %s", test, field);
    end
  endtask

  task automatic flag_check(input string test, input string field, input logic exp,
                            input logic act);
    assert (act === exp)
    else
    begin
      $display("[ERROR] %s: %s expected %0b, actual %0b", test, field, exp, act);
      $display(">>> FAIL");
      $fatal(1, "%s: wrong value on %s", test, field);
    end
  endtask

  // valid plus every control bit
  task automatic ctrl_check(input string test, input logic rw, input logic m2r,
                            input logic mr, input logic mw, input logic bt, input logic ill);
    flag_check(test, "ex_valid", 1'b1, ex_valid);
    flag_check(test, "ex_ctrl_reg_write", rw, ex_ctrl_reg_write);
    flag_check(test, "ex_mem_to_reg", m2r, ex_mem_to_reg);
    flag_check(test, "ex_mem_read", mr, ex_mem_read);
    flag_check(test, "ex_mem_write", mw, ex_mem_write);
    flag_check(test, "ex_branch_taken", bt, ex_branch_taken);
    flag_check(test, "ex_illegal", ill, ex_illegal);
  endtask

  // one write-port cycle, model follows
  task automatic write_reg(input logic [4:0] idx, input logic [31:0] data);
    @(posedge clk);
    wb_en   <= 1'b1;
    wb_rd   <= idx;
    wb_data <= data;
    @(posedge clk);
    wb_en   <= 1'b0;
    if (idx != 5'd31)
      model_regs[idx] = data;
  endtask

  // issue one word, sample mid-cycle after the two-cycle latency
  task automatic issue_wait(input logic [31:0] word, input logic [31:0] pc);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= word;
    instr_pc    <= pc;
    @(posedge clk);
    instr_valid <= 1'b0;
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic reset_and_writeback();
    string t = "reset_and_writeback";
    @(negedge clk);
    flag_check(t, "ex_valid", 1'b0, ex_valid);
    flag_check(t, "ex_ctrl_reg_write", 1'b0, ex_ctrl_reg_write);
    flag_check(t, "ex_mem_to_reg", 1'b0, ex_mem_to_reg);
    flag_check(t, "ex_mem_read", 1'b0, ex_mem_read);
    flag_check(t, "ex_mem_write", 1'b0, ex_mem_write);
    flag_check(t, "ex_branch_taken", 1'b0, ex_branch_taken);
    flag_check(t, "ex_illegal", 1'b0, ex_illegal);
    for (int i = 0; i < 31; i++)
      write_reg(5'(i), next_rand());
    // dropped by the register file
    write_reg(5'd31, next_rand());
    for (int i = 0; i < 32; i++)
    begin
      // orr x0, xi, xzr echoes xi
      issue_wait(r_word(OP_ORR, 5'd31, 5'(i), 5'd0), 32'd0);
      ctrl_check(t, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      word_check(t, "ex_alu_result", model_regs[i], ex_alu_result);
    end
  endtask

  task automatic r_format_ops();
    string       t = "r_format_ops";
    logic [10:0] ops [4];
    logic [4:0]  rn;
    logic [4:0]  rm;
    logic [4:0]  rd;
    logic [31:0] exp;
    ops = '{OP_ADD, OP_SUB, OP_AND, OP_ORR};
    for (int round = 0; round < 3; round++)
    begin
      for (int k = 0; k < 4; k++)
      begin
        rn = 5'(1 + round);
        rm = 5'(10 + k);
        rd = 5'(20 + k);
        write_reg(rn, next_rand());
        write_reg(rm, next_rand());
        exp = rtype_ref(ops[k], model_regs[rn], model_regs[rm]);
        issue_wait(r_word(ops[k], rm, rn, rd), 32'h100);
        ctrl_check(t, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        word_check(t, "ex_rd", {27'd0, rd}, {27'd0, ex_rd});
        word_check(t, "ex_alu_result", exp, ex_alu_result);
      end
    end
  endtask

  task automatic load_store();
    string       t = "load_store";
    logic [8:0]  offs [4];
    logic [31:0] addr;
    // -16, +40, -256, +255
    offs = '{9'h1F0, 9'd40, 9'h100, 9'd255};
    for (int k = 0; k < 4; k++)
    begin
      write_reg(5'd2, next_rand());
      write_reg(5'd4, next_rand());
      addr = model_regs[2] + sext9(offs[k]);
      issue_wait(d_word(OP_LDUR, offs[k], 5'd2, 5'd3), 32'h200);
      ctrl_check(t, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
      word_check(t, "ex_rd", 32'd3, {27'd0, ex_rd});
      word_check(t, "ex_alu_result", addr, ex_alu_result);
      issue_wait(d_word(OP_STUR, offs[k], 5'd2, 5'd4), 32'h204);
      ctrl_check(t, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
      word_check(t, "ex_alu_result", addr, ex_alu_result);
      word_check(t, "ex_store_data", model_regs[4], ex_store_data);
    end
  endtask

  task automatic cbz_branch();
    string t = "cbz_branch";
    write_reg(5'd8, 32'd0);
    write_reg(5'd9, next_rand() | 32'd1);
    // +5 words, rt zero
    issue_wait(cb_word(19'd5, 5'd8), 32'h1000);
    ctrl_check(t, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    word_check(t, "ex_branch_target", 32'h1014, ex_branch_target);
    // -3 words, rt nonzero
    issue_wait(cb_word(19'h7FFFD, 5'd9), 32'h1000);
    ctrl_check(t, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    word_check(t, "ex_branch_target", 32'h0FF4, ex_branch_target);
    // -256 words on xzr
    issue_wait(cb_word(19'h7FF00, 5'd31), 32'h2000);
    ctrl_check(t, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    word_check(t, "ex_branch_target", 32'h1C00, ex_branch_target);
  endtask

  task automatic back_to_back_issue();
    string       t = "back_to_back_issue";
    logic [31:0] new_val;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    logic [31:0] exp_c;
    write_reg(5'd10, next_rand());
    write_reg(5'd11, next_rand());
    new_val = next_rand();
    exp_a = model_regs[10] + model_regs[11];
    exp_b = new_val - model_regs[11];
    exp_c = new_val | model_regs[11];
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= r_word(OP_ADD, 5'd11, 5'd10, 5'd12);
    instr_pc    <= 32'h300;
    @(posedge clk);
    // x10 rewritten in the sub's issue cycle
    instr       <= r_word(OP_SUB, 5'd11, 5'd10, 5'd13);
    instr_pc    <= 32'h304;
    wb_en       <= 1'b1;
    wb_rd       <= 5'd10;
    wb_data     <= new_val;
    @(posedge clk);
    instr       <= r_word(OP_ORR, 5'd11, 5'd10, 5'd14);
    instr_pc    <= 32'h308;
    wb_en       <= 1'b0;
    model_regs[10] = new_val;
    @(negedge clk);
    ctrl_check(t, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    word_check(t, "ex_rd", 32'd12, {27'd0, ex_rd});
    word_check(t, "ex_alu_result", exp_a, ex_alu_result);
    @(posedge clk);
    instr_valid <= 1'b0;
    @(negedge clk);
    ctrl_check(t, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    word_check(t, "ex_rd", 32'd13, {27'd0, ex_rd});
    word_check(t, "ex_alu_result", exp_b, ex_alu_result);
    @(negedge clk);
    ctrl_check(t, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    word_check(t, "ex_rd", 32'd14, {27'd0, ex_rd});
    word_check(t, "ex_alu_result", exp_c, ex_alu_result);
    // pipeline drained
    @(negedge clk);
    flag_check(t, "ex_valid", 1'b0, ex_valid);
  endtask

  task automatic illegal_opcode();
    string       t = "illegal_opcode";
    logic [31:0] words [3];
    // zero word, all ones, add with one opcode bit off
    words = '{32'h0000_0000, 32'hFFFF_FFFF, 32'h8B20_0000};
    for (int k = 0; k < 3; k++)
    begin
      issue_wait(words[k], 32'h400);
      ctrl_check(t, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    end
    // next legal word clears the flag
    issue_wait(r_word(OP_ADD, 5'd31, 5'd31, 5'd1), 32'h40C);
    ctrl_check(t, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  initial
  begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    instr_pc    = '0;
    wb_en       = 1'b0;
    wb_rd       = '0;
    wb_data     = '0;
    lcg_state   = 32'hf558;
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    reset_and_writeback();
    r_format_ops();
    load_store();
    cbz_branch();
    back_to_back_issue();
    illegal_opcode();
    $display(">>> PASS");
    $finish;
  end

  // run limit from test count and per-test cycle budget
  initial
  begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("timeout: tests did not finish within the cycle budget");
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- legv8_id_ex.f
source/legv8_isa_pkg.sv
source/legv8_pipe_pkg.sv
source/id_ex_if.sv
source/inst_decoder.sv
source/reg_file.sv
source/id_ex_reg.sv
source/ex_stage.sv
source/id_ex_core.sv
verification/id_ex_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the id/ex testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f legv8_id_ex.f \
  --top-module id_ex_core_tb \
  -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

echo "simulation exited cleanly"
exit 0
